// File: design/fdc_params.svh
`ifndef FDC_PARAMS_SVH
`define FDC_PARAMS_SVH

////////////////////////////////////////////////////////////
// Register map, low address byte

// SRAM access window
`define FDC_ADDR_SRAM_LOW      8'h00
`define FDC_ADDR_SRAM_HIGH     8'h01
`define FDC_ADDR_SRAM_UPPER    8'h02   // Only 3 bits implemented
`define FDC_ADDR_SRAM_DATA     8'h03

// Identification bytes
`define FDC_ADDR_ID_TYPE_L     8'h04
`define FDC_ADDR_ID_TYPE_H     8'h05
`define FDC_ADDR_ID_VER_L      8'h06
`define FDC_ADDR_ID_VER_H      8'h07

`define FDC_ADDR_STATUS        8'h0E

// Bus test registers
`define FDC_ADDR_SCRATCH       8'h30
`define FDC_ADDR_SCRATCH_INV   8'h31
`define FDC_ADDR_FIXED_55      8'h32
`define FDC_ADDR_FIXED_AA      8'h33

// Index period, read high byte first
`define FDC_ADDR_INDEX_HIGH    8'h40
`define FDC_ADDR_INDEX_LOW     8'h41

////////////////////////////////////////////////////////////
// Identification and sizing

`define FDC_ID_TYPE            16'hDD55
`define FDC_ID_VERSION         16'h0025

`define FDC_TICK_CYCLES        1000    // 10 us at 100 MHz
`define FDC_FIFO_DEPTH         16

`endif

// File: design/fdc_pkg.sv
package fdc_pkg;

	// One byte on the host or SRAM data bus
	typedef logic [7:0] byte_t;

	// Low address byte, the only one decoded
	typedef logic [7:0] reg_addr_t;

	// 512K x 8 SRAM address
	typedef logic [18:0] sram_addr_t;

	// Index period in 10 us ticks
	typedef logic [15:0] index_count_t;

	// Memory write controller states
	typedef enum logic [2:0] {
		MWC_IDLE,       // OE active, waiting for data
		MWC_OE_OFF,     // SRAM outputs off, FIFO pops
		MWC_WRITE,      // WE low for one cycle
		MWC_WRITE_END,  // WE back high
		MWC_INC_ADDR    // Bump address
	} mwc_state_t;

endpackage

// File: design/fdc_timebase.sv
`include "fdc_params.svh"

module fdc_timebase #(
	parameter int TICK_CYCLES = `FDC_TICK_CYCLES
) (
	input  logic CLK_MASTER,
	input  logic rst_n,
	output logic tick_10us
);

	localparam int CNT_W = (TICK_CYCLES > 1) ? $clog2(TICK_CYCLES) : 1;
	localparam logic [CNT_W-1:0] LAST = CNT_W'(TICK_CYCLES - 1);

	logic [CNT_W-1:0] tick_cnt;  // Cycles into current tick period

	// Free-running divider, wraps at TICK_CYCLES
	always_ff @(posedge CLK_MASTER) begin
		if (!rst_n) begin
			tick_cnt <= '0;
		end else if (tick_cnt == LAST) begin
			tick_cnt <= '0;
		end else begin
			tick_cnt <= tick_cnt + 1'b1;
		end
	end

	// One-cycle enable on wrap
	assign tick_10us = (tick_cnt == LAST);

endmodule

// File: design/fdc_index_meter.sv
module fdc_index_meter import fdc_pkg::*; (
	input  logic  CLK_MASTER,
	input  logic  rst_n,
	input  logic  index_in,       // Raw index pulse from drive
	input  logic  tick_10us,      // Timebase enable
	input  logic  index_hi_read,  // Host just read the high byte
	output byte_t period_high,
	output byte_t period_low,
	output logic  new_index
);

	logic [1:0]   index_sync;   // Two-flop synchroniser
	logic         index_rise;
	index_count_t period_cnt;   // Running tick count
	index_count_t period_lat;   // Last full measurement

	always_ff @(posedge CLK_MASTER) begin
		if (!rst_n)
			index_sync <= '0;
		else
			index_sync <= {index_sync[0], index_in};
	end

	assign index_rise = index_sync[0] & ~index_sync[1];  // Low to high

	////////////////////////////////////////////////////////////
	// Period counter

	always_ff @(posedge CLK_MASTER) begin
		if (!rst_n) begin
			period_cnt <= '0;
		end else if (index_rise) begin
			period_lat <= period_cnt;    // Save count, restart
			period_cnt <= '0;
		end else if (tick_10us) begin
			period_cnt <= period_cnt + 1'b1;
		end
	end

	// Freeze low byte on high read so the pair never tears
	always_ff @(posedge CLK_MASTER) begin
		if (index_hi_read)
			period_low <= period_lat[7:0];
	end

	assign period_high = period_lat[15:8];

	// New measurement flag, read clear wins over edge set
	always_ff @(posedge CLK_MASTER) begin
		if (!rst_n)
			new_index <= 1'b0;
		else if (index_hi_read)
			new_index <= 1'b0;
		else if (index_rise)
			new_index <= 1'b1;
	end

endmodule

// File: design/fdc_byte_fifo.sv
`include "fdc_params.svh"

module fdc_byte_fifo import fdc_pkg::*; #(
	parameter int DEPTH = `FDC_FIFO_DEPTH
) (
	input  logic  CLK_MASTER,
	input  logic  rst_n,
	input  logic  push,
	input  byte_t push_data,
	input  logic  pop,
	output byte_t pop_data,    // Registered, loads on pop
	output logic  not_empty,
	output logic  overflow     // Sticky until reset
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	byte_t            mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;       // Bytes held
	logic             full;
	logic             do_push;
	logic             do_pop;

	// Pointer step with wrap for any depth
	function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign full      = (count == CNT_W'(DEPTH));
	assign not_empty = (count != '0);
	assign do_push   = push & ~full;       // Push into full is dropped
	assign do_pop    = pop & not_empty;

	// Storage and output register
	always_ff @(posedge CLK_MASTER) begin
		if (do_push)
			mem[wr_ptr] <= push_data;
		if (do_pop)
			pop_data <= mem[rd_ptr];
	end

	always_ff @(posedge CLK_MASTER) begin
		if (!rst_n) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			count    <= '0;
			overflow <= 1'b0;
		end else begin
			if (do_push)
				wr_ptr <= ptr_next(wr_ptr);
			if (do_pop)
				rd_ptr <= ptr_next(rd_ptr);
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;     // Both or neither
			endcase
			if (push && full)
				overflow <= 1'b1;
		end
	end

endmodule

// File: design/fdc_sram_writer.sv
module fdc_sram_writer import fdc_pkg::*; (
	input  logic CLK_MASTER,
	input  logic rst_n,
	input  logic fifo_not_empty,
	output logic fifo_pop,
	output logic sram_we_n,
	output logic sram_oe_n,
	output logic mwc_inc      // Address bump after write
);

	mwc_state_t state;
	mwc_state_t state_nxt;

	////////////////////////////////////////////////////////////
	// Write sequencer

	always_ff @(posedge CLK_MASTER) begin
		if (!rst_n)
			state <= MWC_IDLE;
		else
			state <= state_nxt;
	end

	// Five cycles per byte, back to idle between bytes
	always_comb begin
		case (state)
			MWC_IDLE: begin
				if (fifo_not_empty)
					state_nxt = MWC_OE_OFF;
				else
					state_nxt = MWC_IDLE;
			end
			MWC_OE_OFF:    state_nxt = MWC_WRITE;      // FIFO output loads here
			MWC_WRITE:     state_nxt = MWC_WRITE_END;
			MWC_WRITE_END: state_nxt = MWC_INC_ADDR;
			MWC_INC_ADDR:  state_nxt = MWC_IDLE;
			default:       state_nxt = MWC_IDLE;       // Stray encodings recover
		endcase
	end

	// Moore outputs straight from state
	// OE only in idle so the SRAM never drives while we write
	assign sram_oe_n = (state != MWC_IDLE);
	assign sram_we_n = (state != MWC_WRITE);      // Single-cycle strobe
	assign fifo_pop  = (state == MWC_OE_OFF);
	assign mwc_inc   = (state == MWC_INC_ADDR);

endmodule

// File: design/fdc_addr_counter.sv
module fdc_addr_counter import fdc_pkg::*; (
	input  logic       CLK_MASTER,
	input  logic       rst_n,
	input  logic       load_low,     // Bits 7..0
	input  logic       load_high,    // Bits 15..8
	input  logic       load_upper,   // Bits 18..16
	input  byte_t      load_data,
	input  logic       mwc_inc,      // From write controller
	input  logic       rd_done_inc,  // From host read
	output sram_addr_t sram_a
);

	logic addr_inc;

	assign addr_inc = mwc_inc | rd_done_inc;

	////////////////////////////////////////////////////////////
	// SRAM address register

	always_ff @(posedge CLK_MASTER) begin
		if (!rst_n) begin
			sram_a <= '0;
		end else if (load_low || load_high || load_upper) begin
			// Host loads take priority
			if (load_low)
				sram_a[7:0] <= load_data;
			if (load_high)
				sram_a[15:8] <= load_data;
			if (load_upper)
				sram_a[18:16] <= load_data[2:0];  // Top bits dropped
		end else if (addr_inc) begin
			sram_a <= sram_a + 1'b1;              // Wraps at 19 bits
		end
	end

endmodule

// File: design/fdc_host_regs.sv
`include "fdc_params.svh"

module fdc_host_regs import fdc_pkg::*; (
	input  logic       CLK_MASTER,
	input  logic       rst_n,
	input  logic       mcu_alh,         // Address high load level
	input  logic       mcu_all,         // Address low load level
	input  logic       mcu_rd,
	input  logic       mcu_wr,
	input  byte_t      mcu_wdata,
	input  byte_t      sram_dq_in,
	input  sram_addr_t sram_a,
	input  logic       fifo_not_empty,
	input  logic       overflow,
	input  logic       new_index,
	input  byte_t      period_high,
	input  byte_t      period_low,
	output byte_t      mcu_rdata,
	output logic       fifo_push,
	output logic       load_low,
	output logic       load_high,
	output logic       load_upper,
	output logic       rd_done_inc,
	output logic       index_hi_read
);

	localparam logic [15:0] ID_TYPE = `FDC_ID_TYPE;
	localparam logic [15:0] ID_VER  = `FDC_ID_VERSION;

	byte_t     addr_high;    // Page byte, registers live in page 0
	reg_addr_t addr_low;
	logic      page_sel;
	logic      wr_q;
	logic      rd_q;
	logic      wr_pulse;
	logic      wr_sel;
	logic      at_data;
	byte_t     scratch;
	byte_t     sram_lat;     // SRAM byte held through a read
	byte_t     status;
	byte_t     rd_mux;

	////////////////////////////////////////////////////////////
	// Address latch and strobe edges

	always_ff @(posedge CLK_MASTER) begin
		if (!rst_n) begin
			addr_high <= '0;
			addr_low  <= '0;
		end else begin
			if (mcu_alh)
				addr_high <= mcu_wdata;  // Every clock while high
			if (mcu_all)
				addr_low <= mcu_wdata;
		end
	end

	assign page_sel = (addr_high == '0);
	assign at_data  = page_sel && (addr_low == `FDC_ADDR_SRAM_DATA);

	always_ff @(posedge CLK_MASTER) begin
		if (!rst_n) begin
			wr_q          <= 1'b0;
			rd_q          <= 1'b0;
			wr_pulse      <= 1'b0;
			rd_done_inc   <= 1'b0;
			index_hi_read <= 1'b0;
		end else begin
			wr_q          <= mcu_wr;
			rd_q          <= mcu_rd;
			wr_pulse      <= mcu_wr & ~wr_q;             // One cycle per write
			rd_done_inc   <= ~mcu_rd & rd_q & at_data;   // Falling RD on data reg
			index_hi_read <= mcu_rd & ~rd_q & page_sel
			                 & (addr_low == `FDC_ADDR_INDEX_HIGH);
		end
	end

	////////////////////////////////////////////////////////////
	// Register writes

	assign wr_sel     = wr_pulse & page_sel;
	assign fifo_push  = wr_sel & (addr_low == `FDC_ADDR_SRAM_DATA);
	assign load_low   = wr_sel & (addr_low == `FDC_ADDR_SRAM_LOW);
	assign load_high  = wr_sel & (addr_low == `FDC_ADDR_SRAM_HIGH);
	assign load_upper = wr_sel & (addr_low == `FDC_ADDR_SRAM_UPPER);

	always_ff @(posedge CLK_MASTER) begin
		if (wr_sel && addr_low == `FDC_ADDR_SCRATCH)
			scratch <= mcu_wdata;
		// Track SRAM until RD rises, then hold
		if (!mcu_rd && at_data)
			sram_lat <= sram_dq_in;
	end

	////////////////////////////////////////////////////////////
	// Readback

	assign status = {5'b0, new_index, overflow, fifo_not_empty};

	always_comb begin
		rd_mux = '0;     // Undefined addresses
		if (page_sel) begin
			case (addr_low)
				`FDC_ADDR_SRAM_LOW:    rd_mux = sram_a[7:0];
				`FDC_ADDR_SRAM_HIGH:   rd_mux = sram_a[15:8];
				`FDC_ADDR_SRAM_UPPER:  rd_mux = {5'b0, sram_a[18:16]};
				`FDC_ADDR_SRAM_DATA:   rd_mux = sram_lat;
				`FDC_ADDR_ID_TYPE_L:   rd_mux = ID_TYPE[7:0];
				`FDC_ADDR_ID_TYPE_H:   rd_mux = ID_TYPE[15:8];
				`FDC_ADDR_ID_VER_L:    rd_mux = ID_VER[7:0];
				`FDC_ADDR_ID_VER_H:    rd_mux = ID_VER[15:8];
				`FDC_ADDR_STATUS:      rd_mux = status;
				`FDC_ADDR_SCRATCH:     rd_mux = scratch;
				`FDC_ADDR_SCRATCH_INV: rd_mux = ~scratch;
				`FDC_ADDR_FIXED_55:    rd_mux = 8'h55;
				`FDC_ADDR_FIXED_AA:    rd_mux = 8'hAA;
				`FDC_ADDR_INDEX_HIGH:  rd_mux = period_high;  // Also freezes low byte
				`FDC_ADDR_INDEX_LOW:   rd_mux = period_low;
				default:               rd_mux = '0;
			endcase
		end
	end

	assign mcu_rdata = mcu_rd ? rd_mux : '0;   // Driven only during a read

endmodule

// File: design/fdc_core.sv
`include "fdc_params.svh"

module fdc_core import fdc_pkg::*; #(
	parameter int TICK_CYCLES = `FDC_TICK_CYCLES
) (
	input  logic       CLK_MASTER,
	input  logic       rst_n,
	input  byte_t      mcu_wdata,
	input  logic       mcu_alh,
	input  logic       mcu_all,
	input  logic       mcu_rd,
	input  logic       mcu_wr,
	input  byte_t      sram_dq_in,
	input  logic       index_in,
	output byte_t      mcu_rdata,
	output sram_addr_t sram_a,
	output byte_t      sram_dq_out,
	output logic       sram_we_n,
	output logic       sram_oe_n
);

	logic  tick_10us;
	logic  index_hi_read;
	logic  new_index;
	byte_t period_high;
	byte_t period_low;
	logic  fifo_push;
	logic  fifo_pop;
	logic  fifo_not_empty;
	logic  overflow;
	logic  mwc_inc;
	logic  rd_done_inc;
	logic  load_low;
	logic  load_high;
	logic  load_upper;

	////////////////////////////////////////////////////////////
	// Index timing

	fdc_timebase #(.TICK_CYCLES(TICK_CYCLES)) u_timebase (
		.CLK_MASTER (CLK_MASTER),
		.rst_n      (rst_n),
		.tick_10us  (tick_10us)
	);

	fdc_index_meter u_index_meter (
		.CLK_MASTER    (CLK_MASTER),
		.rst_n         (rst_n),
		.index_in      (index_in),
		.tick_10us     (tick_10us),
		.index_hi_read (index_hi_read),
		.period_high   (period_high),
		.period_low    (period_low),
		.new_index     (new_index)
	);

	////////////////////////////////////////////////////////////
	// SRAM write path

	fdc_byte_fifo u_fifo (
		.CLK_MASTER (CLK_MASTER),
		.rst_n      (rst_n),
		.push       (fifo_push),
		.push_data  (mcu_wdata),
		.pop        (fifo_pop),
		.pop_data   (sram_dq_out),      // FIFO output drives SRAM data
		.not_empty  (fifo_not_empty),
		.overflow   (overflow)
	);

	fdc_sram_writer u_writer (
		.CLK_MASTER     (CLK_MASTER),
		.rst_n          (rst_n),
		.fifo_not_empty (fifo_not_empty),
		.fifo_pop       (fifo_pop),
		.sram_we_n      (sram_we_n),
		.sram_oe_n      (sram_oe_n),
		.mwc_inc        (mwc_inc)
	);

	fdc_addr_counter u_addr (
		.CLK_MASTER  (CLK_MASTER),
		.rst_n       (rst_n),
		.load_low    (load_low),
		.load_high   (load_high),
		.load_upper  (load_upper),
		.load_data   (mcu_wdata),
		.mwc_inc     (mwc_inc),
		.rd_done_inc (rd_done_inc),
		.sram_a      (sram_a)
	);

	////////////////////////////////////////////////////////////
	// Host bus

	fdc_host_regs u_host (
		.CLK_MASTER     (CLK_MASTER),
		.rst_n          (rst_n),
		.mcu_alh        (mcu_alh),
		.mcu_all        (mcu_all),
		.mcu_rd         (mcu_rd),
		.mcu_wr         (mcu_wr),
		.mcu_wdata      (mcu_wdata),
		.sram_dq_in     (sram_dq_in),
		.sram_a         (sram_a),
		.fifo_not_empty (fifo_not_empty),
		.overflow       (overflow),
		.new_index      (new_index),
		.period_high    (period_high),
		.period_low     (period_low),
		.mcu_rdata      (mcu_rdata),
		.fifo_push      (fifo_push),
		.load_low       (load_low),
		.load_high      (load_high),
		.load_upper     (load_upper),
		.rd_done_inc    (rd_done_inc),
		.index_hi_read  (index_hi_read)
	);

endmodule

// File: testbench/fdc_properties.sv
`include "fdc_params.svh"

module fdc_properties import fdc_pkg::*; #(
	parameter int TICK_CYCLES = `FDC_TICK_CYCLES
) (
	input logic       CLK_MASTER,
	input logic       rst_n,
	input byte_t      mcu_wdata,
	input logic       mcu_alh,
	input logic       mcu_all,
	input logic       mcu_rd,
	input logic       mcu_wr,
	input byte_t      sram_dq_in,
	input logic       index_in,
	input byte_t      mcu_rdata,
	input sram_addr_t sram_a,
	input byte_t      sram_dq_out,
	input logic       sram_we_n,
	input logic       sram_oe_n
);

	localparam logic [15:0] ID_TYPE = `FDC_ID_TYPE;
	localparam logic [15:0] ID_VER  = `FDC_ID_VERSION;

	// Last failure, picked up by the testbench report
	int          fail_count = 0;
	string       last_sig = "";
	logic [31:0] last_exp;
	logic [31:0] last_got;
	time         last_time;

	// Host bus shadow
	byte_t       addr_h;
	reg_addr_t   addr_l;
	logic        wr_q;
	logic        rd_q;
	logic        page0;
	logic        at_data;
	byte_t       scratch_sh;      // Last scratchpad write
	byte_t       exp_rd;
	logic        rd_known;        // Register with a predictable readback

	// SRAM write shadow
	sram_addr_t  exp_a;           // Where the next access must land
	byte_t       wq [$];          // Bytes written to 03, not yet in SRAM
	logic        q_any;
	byte_t       q_head;

	// Index shadow
	logic [1:0]  idx_sync;
	int unsigned cyc_cnt;         // Clocks since last index rise
	int unsigned meas_ticks;
	int unsigned exp_ticks;       // Frozen at the high byte read
	byte_t       hi_cap;
	logic        new_sh;
	logic [31:0] idx_got;
	logic        idx_ok;

	task automatic note_failure(input string sig, input logic [31:0] exp,
	                            input logic [31:0] got);
		fail_count++;
		last_sig  = sig;
		last_exp  = exp;
		last_got  = got;
		last_time = $time;
		$error("%s expected 0x%0h, got 0x%0h", sig, exp, got);
	endtask

	assign page0   = (addr_h == 8'h00);
	assign at_data = page0 && (addr_l == `FDC_ADDR_SRAM_DATA);
	assign idx_got = {16'h0, hi_cap, mcu_rdata};
	assign idx_ok  = (idx_got + 1 >= exp_ticks) && (idx_got <= exp_ticks + 1);  // Within one tick

	////////////////////////////////////////////////////////////
	// Expected readback from the register map

	always_comb begin
		rd_known = page0;
		exp_rd   = '0;         // Undefined addresses read zero
		case (addr_l)
			`FDC_ADDR_SRAM_LOW:    exp_rd = exp_a[7:0];
			`FDC_ADDR_SRAM_HIGH:   exp_rd = exp_a[15:8];
			`FDC_ADDR_SRAM_UPPER:  exp_rd = {5'b0, exp_a[18:16]};
			`FDC_ADDR_ID_TYPE_L:   exp_rd = ID_TYPE[7:0];
			`FDC_ADDR_ID_TYPE_H:   exp_rd = ID_TYPE[15:8];
			`FDC_ADDR_ID_VER_L:    exp_rd = ID_VER[7:0];
			`FDC_ADDR_ID_VER_H:    exp_rd = ID_VER[15:8];
			`FDC_ADDR_STATUS:      exp_rd = {5'b0, new_sh, 1'b0, q_any};  // No overflow expected
			`FDC_ADDR_SCRATCH:     exp_rd = scratch_sh;
			`FDC_ADDR_SCRATCH_INV: exp_rd = ~scratch_sh;
			`FDC_ADDR_FIXED_55:    exp_rd = 8'h55;
			`FDC_ADDR_FIXED_AA:    exp_rd = 8'hAA;
			`FDC_ADDR_SRAM_DATA,
			`FDC_ADDR_INDEX_HIGH,
			`FDC_ADDR_INDEX_LOW:   rd_known = 1'b0;  // Own assertions
			default:               exp_rd = '0;
		endcase
	end

	////////////////////////////////////////////////////////////
	// Shadow state

	always @(posedge CLK_MASTER) begin
		if (!rst_n) begin
			addr_h     <= '0;
			addr_l     <= '0;
			wr_q       <= 1'b0;
			rd_q       <= 1'b0;
			exp_a      <= '0;
			wq.delete();
			q_any      <= 1'b0;
			q_head     <= '0;
			idx_sync   <= '0;
			cyc_cnt    <= 0;
			meas_ticks <= 0;
			new_sh     <= 1'b0;
		end else begin
			wr_q <= mcu_wr;
			rd_q <= mcu_rd;
			if (mcu_alh)
				addr_h <= mcu_wdata;
			if (mcu_all)
				addr_l <= mcu_wdata;
			// One byte lands in SRAM
			if (!sram_we_n) begin
				exp_a <= exp_a + 1'b1;
				if (wq.size() != 0)
					void'(wq.pop_front());
			end
			if (rd_q && !mcu_rd && at_data)
				exp_a <= exp_a + 1'b1;   // Read done
			// Host write on rising WR, loads win over increments
			if (mcu_wr && !wr_q && page0) begin
				case (addr_l)
					`FDC_ADDR_SRAM_LOW:   exp_a[7:0]   <= mcu_wdata;
					`FDC_ADDR_SRAM_HIGH:  exp_a[15:8]  <= mcu_wdata;
					`FDC_ADDR_SRAM_UPPER: exp_a[18:16] <= mcu_wdata[2:0];
					`FDC_ADDR_SRAM_DATA:  wq.push_back(mcu_wdata);
					`FDC_ADDR_SCRATCH:    scratch_sh   <= mcu_wdata;
					default: ;
				endcase
			end
			q_any  <= (wq.size() != 0);
			q_head <= (wq.size() != 0) ? wq[0] : 8'h00;

			// Index period in whole ticks
			idx_sync <= {idx_sync[0], index_in};
			if (idx_sync[0] && !idx_sync[1]) begin
				meas_ticks <= (cyc_cnt + 1) / TICK_CYCLES;
				cyc_cnt    <= 0;
				new_sh     <= 1'b1;
			end else begin
				cyc_cnt <= cyc_cnt + 1;
			end
			if (mcu_rd && page0 && addr_l == `FDC_ADDR_INDEX_HIGH) begin
				hi_cap    <= mcu_rdata;
				exp_ticks <= meas_ticks;
				if (!rd_q)
					new_sh <= 1'b0;      // High read clears the flag
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Assertions

	a_rdata: assert property (@(posedge CLK_MASTER) disable iff (!rst_n)
		(mcu_rd && rd_known) |-> mcu_rdata == exp_rd)
		else note_failure("mcu_rdata", $sampled(exp_rd), $sampled(mcu_rdata));

	a_sram_rdata: assert property (@(posedge CLK_MASTER) disable iff (!rst_n)
		(mcu_rd && at_data) |-> mcu_rdata == sram_dq_in)
		else note_failure("mcu_rdata from SRAM", $sampled(sram_dq_in), $sampled(mcu_rdata));

	a_read_addr: assert property (@(posedge CLK_MASTER) disable iff (!rst_n)
		(mcu_rd && at_data) |-> sram_a == exp_a)
		else note_failure("sram_a on read", $sampled(exp_a), $sampled(sram_a));

	a_we_single: assert property (@(posedge CLK_MASTER) disable iff (!rst_n)
		!sram_we_n |=> sram_we_n)
		else note_failure("sram_we_n pulse width", 1, 0);

	a_we_oe: assert property (@(posedge CLK_MASTER) disable iff (!rst_n)
		!sram_we_n |-> sram_oe_n && $past(sram_oe_n))
		else note_failure("sram_oe_n during write", 1, $sampled(sram_oe_n));

	a_we_queued: assert property (@(posedge CLK_MASTER) disable iff (!rst_n)
		!sram_we_n |-> q_any)
		else note_failure("sram_we_n with no byte queued", 1, 0);

	a_we_data: assert property (@(posedge CLK_MASTER) disable iff (!rst_n)
		(!sram_we_n && q_any) |-> sram_dq_out == q_head)
		else note_failure("sram_dq_out", $sampled(q_head), $sampled(sram_dq_out));

	a_we_addr: assert property (@(posedge CLK_MASTER) disable iff (!rst_n)
		!sram_we_n |-> sram_a == exp_a)
		else note_failure("sram_a on write", $sampled(exp_a), $sampled(sram_a));

	a_index: assert property (@(posedge CLK_MASTER) disable iff (!rst_n)
		(mcu_rd && page0 && addr_l == `FDC_ADDR_INDEX_LOW) |-> idx_ok)
		else note_failure("index period", $sampled(exp_ticks), $sampled(idx_got));

endmodule

bind fdc_core fdc_properties #(.TICK_CYCLES(TICK_CYCLES)) u_props (
	.CLK_MASTER  (CLK_MASTER),
	.rst_n       (rst_n),
	.mcu_wdata   (mcu_wdata),
	.mcu_alh     (mcu_alh),
	.mcu_all     (mcu_all),
	.mcu_rd      (mcu_rd),
	.mcu_wr      (mcu_wr),
	.sram_dq_in  (sram_dq_in),
	.index_in    (index_in),
	.mcu_rdata   (mcu_rdata),
	.sram_a      (sram_a),
	.sram_dq_out (sram_dq_out),
	.sram_we_n   (sram_we_n),
	.sram_oe_n   (sram_oe_n)
);

// File: testbench/fdc_tb.sv
`include "fdc_params.svh"

module fdc_tb import fdc_pkg::*; ();

	localparam int CLK_PERIOD   = 40;
	localparam int TICK         = 20;     // Short tick for simulation
	localparam int RESET_CYCLES = 8;
	localparam int N_TICKS      = 300;    // Index spacing, above one byte
	localparam int BURST        = 12;
	localparam int BUS_OPS      = 48;     // Upper bound on bus transfers
	localparam int OP_CYCLES    = 7;      // Longest bus transfer
	localparam int WATCHDOG_CYCLES = 2 * (RESET_CYCLES + 3 * N_TICKS * TICK
	                                 + BUS_OPS * OP_CYCLES + BURST * 5) + 1000;

	logic       CLK_MASTER;
	logic       rst_n;
	byte_t      mcu_wdata;
	logic       mcu_alh;
	logic       mcu_all;
	logic       mcu_rd;
	logic       mcu_wr;
	byte_t      sram_dq_in;
	logic       index_in;
	byte_t      mcu_rdata;
	sram_addr_t sram_a;
	byte_t      sram_dq_out;
	logic       sram_we_n;
	logic       sram_oe_n;

	logic [31:0] lfsr = 32'hb5e98db9;
	byte_t       sram_mem [0:(1 << 19) - 1];
	int          we_count = 0;         // Write pulses seen by the SRAM
	byte_t       base [3];             // Burst start address bytes
	int          tests_run = 0;
	int          tests_failed = 0;
	int          tb_errs = 0;
	int          prop_mark = 0;
	int          tb_mark = 0;

	fdc_core #(.TICK_CYCLES(TICK)) u_dut (
		.CLK_MASTER  (CLK_MASTER),
		.rst_n       (rst_n),
		.mcu_wdata   (mcu_wdata),
		.mcu_alh     (mcu_alh),
		.mcu_all     (mcu_all),
		.mcu_rd      (mcu_rd),
		.mcu_wr      (mcu_wr),
		.sram_dq_in  (sram_dq_in),
		.index_in    (index_in),
		.mcu_rdata   (mcu_rdata),
		.sram_a      (sram_a),
		.sram_dq_out (sram_dq_out),
		.sram_we_n   (sram_we_n),
		.sram_oe_n   (sram_oe_n)
	);

	always #(CLK_PERIOD / 2) CLK_MASTER = ~CLK_MASTER;

	////////////////////////////////////////////////////////////
	// SRAM model and random bytes

	assign sram_dq_in = sram_oe_n ? 8'h00 : sram_mem[sram_a];  // Outputs off while writing

	always @(posedge CLK_MASTER) begin
		if (!sram_we_n) begin
			sram_mem[sram_a] <= sram_dq_out;
			we_count <= we_count + 1;
		end
	end

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic rand_byte(output byte_t b);
		for (int i = 0; i < 8; i++) begin
			lfsr = lfsr_next(lfsr);
			b = {b[6:0], lfsr[0]};   // One new bit per step
		end
	endtask

	////////////////////////////////////////////////////////////
	// Host bus, inputs move on the falling edge

	task automatic set_addr(input reg_addr_t a);
		mcu_wdata = 8'h00;
		mcu_alh = 1'b1;              // Page 0
		@(negedge CLK_MASTER);
		mcu_alh = 1'b0;
		mcu_wdata = a;
		mcu_all = 1'b1;
		@(negedge CLK_MASTER);
		mcu_all = 1'b0;
		@(negedge CLK_MASTER);       // Idle so the SRAM latch sees the address
	endtask

	task automatic reg_write(input reg_addr_t a, input byte_t d);
		set_addr(a);
		mcu_wdata = d;
		mcu_wr = 1'b1;
		repeat (2) @(negedge CLK_MASTER);
		mcu_wr = 1'b0;
		@(negedge CLK_MASTER);
	endtask

	task automatic reg_read(input reg_addr_t a);
		set_addr(a);
		mcu_rd = 1'b1;
		repeat (2) @(negedge CLK_MASTER);
		mcu_rd = 0;
		@(negedge CLK_MASTER);
	endtask

	// Wait for the writer to drain, bounded
	task automatic wait_writes(input int target);
		int waited;
		waited = 0;
		while (we_count < target && waited < BURST * 10 + 50) begin
			@(negedge CLK_MASTER);
			waited++;
		end
		if (we_count < target) begin
			tb_errs++;
			$display("SRAM burst stalled, %0d of %0d write pulses seen", we_count, target);
		end
		waited = 0;
		while (sram_oe_n && waited < 16) begin
			@(negedge CLK_MASTER);
			waited++;
		end
		if (sram_oe_n) begin
			tb_errs++;
			$display("Write controller never returned to idle");
		end
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (u_dut.u_props.fail_count != prop_mark) begin
			tests_failed++;
			$display("Fail at %0t: %s expected 0x%0h, got 0x%0h (%s)",
			         u_dut.u_props.last_time, u_dut.u_props.last_sig,
			         u_dut.u_props.last_exp, u_dut.u_props.last_got, name);
		end else if (tb_errs != tb_mark) begin
			tests_failed++;
			$display("%s: failed, DUT did not finish its writes", name);
		end else begin
			$display("%s: pass", name);
		end
		prop_mark = u_dut.u_props.fail_count;
		tb_mark = tb_errs;
	endtask

	////////////////////////////////////////////////////////////
	// Tests

	task automatic test_ident();
		reg_read(`FDC_ADDR_ID_TYPE_L);
		reg_read(`FDC_ADDR_ID_TYPE_H);
		reg_read(`FDC_ADDR_ID_VER_L);
		reg_read(`FDC_ADDR_ID_VER_H);
		reg_read(`FDC_ADDR_FIXED_55);
		reg_read(`FDC_ADDR_FIXED_AA);
	endtask

	task automatic test_scratch();
		byte_t d;
		rand_byte(d);
		reg_write(`FDC_ADDR_SCRATCH, d);
		reg_read(`FDC_ADDR_SCRATCH);
		reg_read(`FDC_ADDR_SCRATCH_INV);
	endtask

	task automatic test_addr();
		byte_t d;
		for (int i = 0; i < 3; i++) begin
			rand_byte(d);
			reg_write(reg_addr_t'(i), d);   // Upper byte keeps 3 bits
		end
		for (int i = 0; i < 3; i++)
			reg_read(reg_addr_t'(i));
	endtask

	task automatic test_burst();
		byte_t d;
		int    target;
		for (int i = 0; i < 3; i++) begin
			rand_byte(base[i]);
			reg_write(reg_addr_t'(i), base[i]);
		end
		target = we_count + BURST;
		for (int i = 0; i < BURST; i++) begin
			rand_byte(d);
			reg_write(`FDC_ADDR_SRAM_DATA, d);
		end
		wait_writes(target);
		reg_read(`FDC_ADDR_STATUS);     // FIFO empty, no flags
	endtask

	task automatic test_sram_read();
		for (int i = 0; i < 3; i++)
			reg_write(reg_addr_t'(i), base[i]);
		reg_read(`FDC_ADDR_SRAM_DATA);  // First burst byte
		reg_read(`FDC_ADDR_SRAM_DATA);
		reg_read(`FDC_ADDR_SRAM_LOW);   // Base plus two
		reg_read(`FDC_ADDR_SRAM_HIGH);
		reg_read(`FDC_ADDR_SRAM_UPPER);
	endtask

	task automatic test_index();
		for (int i = 0; i < 3; i++) begin
			if (i > 0)
				repeat (N_TICKS * TICK - 4) @(negedge CLK_MASTER);
			index_in = 1'b1;
			repeat (4) @(negedge CLK_MASTER);
			index_in = 1'b0;
		end
		repeat (4) @(negedge CLK_MASTER);  // Through the synchroniser
		reg_read(`FDC_ADDR_STATUS);
		reg_read(`FDC_ADDR_INDEX_HIGH);
		reg_read(`FDC_ADDR_INDEX_LOW);
		reg_read(`FDC_ADDR_STATUS);
	endtask

	initial begin
		CLK_MASTER = 1'b0;
		rst_n = 1'b0;
		mcu_wdata = 8'h00;
		mcu_alh = 1'b0;
		mcu_all = 1'b0;
		mcu_rd = 1'b0;
		mcu_wr = 1'b0;
		index_in = 1'b0;
		for (int i = 0; i < (1 << 19); i++)
			sram_mem[i] = byte_t'(i ^ (i >> 8) ^ (i >> 16) ^ 8'h5A);  // Whole-address fill
		repeat (RESET_CYCLES) @(negedge CLK_MASTER);
		rst_n = 1'b1;
		@(negedge CLK_MASTER);

		test_ident();
		end_test("Identification and fixed bytes");
		test_scratch();
		end_test("Scratchpad and inverse");
		test_addr();
		end_test("Address byte loads");
		test_burst();
		end_test("SRAM write burst");
		test_sram_read();
		end_test("SRAM readback");
		test_index();
		end_test("Index period");

		$display("Tests run %0d, failed %0d, assertion failures %0d, other errors %0d",
		         tests_run, tests_failed, u_dut.u_props.fail_count, tb_errs);
		if (tests_failed == 0 && u_dut.u_props.fail_count == 0 && tb_errs == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

	// Ends a hung run
	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog: run timed out after %0d cycles", WATCHDOG_CYCLES);
		$display("Simulation failed");
		$finish;
	end

endmodule

// File: fdc_core.f
+incdir+design
design/fdc_pkg.sv
design/fdc_timebase.sv
design/fdc_index_meter.sv
design/fdc_byte_fifo.sv
design/fdc_sram_writer.sv
design/fdc_addr_counter.sv
design/fdc_host_regs.sv
design/fdc_core.sv
testbench/fdc_properties.sv
testbench/fdc_tb.sv

// File: Bender.yml
package:
  name: fdc_core

sources:
  - include_dirs:
      - design
    files:
      - design/fdc_pkg.sv
      - design/fdc_timebase.sv
      - design/fdc_index_meter.sv
      - design/fdc_byte_fifo.sv
      - design/fdc_sram_writer.sv
      - design/fdc_addr_counter.sv
      - design/fdc_host_regs.sv
      - design/fdc_core.sv
  - target: test
    include_dirs:
      - design
    files:
      - testbench/fdc_properties.sv
      - testbench/fdc_tb.sv
